// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module km_tb -o km_sim

status=0
./obj_dir/km_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "Simulation passed"
exit 0

// File: src/km_accumulator.sv
`timescale 1ns/1ps
`include "km_params.svh"

module km_accumulator (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_clear,
  input  logic             i_acc_valid,
  input  km_pkg::idx_t     i_acc_idx,
  input  km_pkg::point_t   i_acc_point,
  input  logic             i_rd_en,
  input  km_pkg::idx_t     i_rd_idx,
  output logic             o_rd_valid,
  output km_pkg::sum_vec_t o_rd_sum,
  output km_pkg::count_t   o_rd_count
);

  // One sum vector and one member count per centroid
  km_pkg::sum_vec_t sums   [`KM_CENTS];
  km_pkg::count_t   counts [`KM_CENTS];

  logic acc_idx_ok;
  logic rd_idx_ok;

  assign acc_idx_ok = (i_acc_idx < km_pkg::idx_t'(`KM_CENTS));
  assign rd_idx_ok  = (i_rd_idx < km_pkg::idx_t'(`KM_CENTS));

  // Clear wins over an accumulation on the same edge
  always_ff @(posedge clk) begin
    if (rst || i_clear) begin
      for (int c = 0; c < `KM_CENTS; c++) begin
        sums[c]   <= '0;
        counts[c] <= '0;
      end
    end else if (i_acc_valid && acc_idx_ok) begin
      for (int d = 0; d < `KM_DIMS; d++) begin
        sums[i_acc_idx][d] <= sums[i_acc_idx][d] + km_pkg::sum_t'(i_acc_point[d]);
      end
      counts[i_acc_idx] <= counts[i_acc_idx] + km_pkg::count_t'(1);
    end
  end

  // Read strobe, one cycle behind the request
  always_ff @(posedge clk) begin
    if (rst) begin
      o_rd_valid <= 1'b0;
    end else begin
      o_rd_valid <= i_rd_en;
    end
  end

  // Samples the stored value before any update on the same edge
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      if (rd_idx_ok) begin
        o_rd_sum   <= sums[i_rd_idx];
        o_rd_count <= counts[i_rd_idx];
      end else begin
        o_rd_sum   <= '0;
        o_rd_count <= '0;
      end
    end
  end

endmodule

// File: src/km_argmin.sv
`timescale 1ns/1ps

module km_argmin (
  input  logic              clk,
  input  logic              rst,
  input  km_pkg::dist_set_t i_dists,
  output km_pkg::idx_t      o_idx,
  output km_pkg::dist_t     o_dist
);

  // Stage 1 winner of 0 against 1, and centroid 2 passed along
  km_pkg::idx_t  s1_idx;
  km_pkg::dist_t s1_dist;
  km_pkg::dist_t s1_pass_dist;

  // Stage 2 overall winner
  km_pkg::idx_t  s2_idx;
  km_pkg::dist_t s2_dist;

  // Strict less-than, so an equal distance goes to the higher index
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_idx       <= '0;
      s1_dist      <= '0;
      s1_pass_dist <= '0;
      s2_idx       <= '0;
      s2_dist      <= '0;
      o_idx        <= '0;
      o_dist       <= '0;
    end else begin
      if (i_dists[0] < i_dists[1]) begin
        s1_idx  <= km_pkg::idx_t'(0);
        s1_dist <= i_dists[0];
      end else begin
        s1_idx  <= km_pkg::idx_t'(1);
        s1_dist <= i_dists[1];
      end
      s1_pass_dist <= i_dists[2];

      if (s1_dist < s1_pass_dist) begin
        s2_idx  <= s1_idx;
        s2_dist <= s1_dist;
      end else begin
        s2_idx  <= km_pkg::idx_t'(2);
        s2_dist <= s1_pass_dist;
      end

      // Output register
      o_idx  <= s2_idx;
      o_dist <= s2_dist;
    end
  end

endmodule

// File: src/km_centroid_regs.sv
`timescale 1ns/1ps
`include "km_params.svh"

module km_centroid_regs (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_cent_wr,
  input  km_pkg::idx_t      i_cent_idx,
  input  km_pkg::point_t    i_cent_point,
  output km_pkg::cent_set_t o_cents
);

  // Reset points, one value replicated over every dimension
  localparam km_pkg::point_t CENT0_RST = {`KM_DIMS{km_pkg::data_t'(`KM_CENT0_INIT)}};
  localparam km_pkg::point_t CENT1_RST = {`KM_DIMS{km_pkg::data_t'(`KM_CENT1_INIT)}};
  localparam km_pkg::point_t CENT2_RST = {`KM_DIMS{km_pkg::data_t'(`KM_CENT2_INIT)}};

  logic idx_ok;

  // Index 3 has no centroid behind it
  assign idx_ok = (i_cent_idx < km_pkg::idx_t'(`KM_CENTS));

  always_ff @(posedge clk) begin
    if (rst) begin
      o_cents[0] <= CENT0_RST;
      o_cents[1] <= CENT1_RST;
      o_cents[2] <= CENT2_RST;
    end else if (i_cent_wr && idx_ok) begin
      // Visible to points accepted from the next cycle on
      o_cents[i_cent_idx] <= i_cent_point;
    end
  end

endmodule

// File: src/km_delay_line.sv
`timescale 1ns/1ps

module km_delay_line #(
  parameter type T     = logic,
  parameter int  DEPTH = 6
) (
  input  logic clk,
  input  logic rst,
  input  T     i_data,
  output T     o_data
);

  T stages [DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        stages[i] <= '0;
      end
    end else begin
      stages[0] <= i_data;
      for (int i = 1; i < DEPTH; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  assign o_data = stages[DEPTH-1];

endmodule

// File: src/km_distance.sv
`timescale 1ns/1ps
`include "km_params.svh"

module km_distance (
  input  logic              clk,
  input  logic              rst,
  input  km_pkg::point_t    i_point,
  input  km_pkg::cent_set_t i_cents,
  output km_pkg::dist_set_t o_dists
);

  // Stage 1 absolute differences, per centroid and dimension
  km_pkg::data_t absdiff [`KM_CENTS][`KM_DIMS];

  // Squares feed the first add stage directly
  logic [2*`KM_DATA_W-1:0] sq [`KM_CENTS][`KM_DIMS];

  // Stage 2 partial sums
  km_pkg::dist_t pair_sum [`KM_CENTS];
  km_pkg::dist_t last_sq  [`KM_CENTS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int c = 0; c < `KM_CENTS; c++) begin
        for (int d = 0; d < `KM_DIMS; d++) begin
          absdiff[c][d] <= '0;
        end
      end
    end else begin
      for (int c = 0; c < `KM_CENTS; c++) begin
        for (int d = 0; d < `KM_DIMS; d++) begin
          // Unsigned operands, so take the larger minus the smaller
          if (i_cents[c][d] > i_point[d]) begin
            absdiff[c][d] <= i_cents[c][d] - i_point[d];
          end else begin
            absdiff[c][d] <= i_point[d] - i_cents[c][d];
          end
        end
      end
    end
  end

  always_comb begin
    for (int c = 0; c < `KM_CENTS; c++) begin
      for (int d = 0; d < `KM_DIMS; d++) begin
        sq[c][d] = absdiff[c][d] * absdiff[c][d];
      end
    end
  end

  // Two add stages, dims 0 and 1 first, then dim 2 joins
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int c = 0; c < `KM_CENTS; c++) begin
        pair_sum[c] <= '0;
        last_sq[c]  <= '0;
        o_dists[c]  <= '0;
      end
    end else begin
      for (int c = 0; c < `KM_CENTS; c++) begin
        pair_sum[c] <= km_pkg::dist_t'(sq[c][0]) + km_pkg::dist_t'(sq[c][1]);
        last_sq[c]  <= km_pkg::dist_t'(sq[c][2]);
        o_dists[c]  <= pair_sum[c] + last_sq[c];
      end
    end
  end

endmodule

// File: src/km_params.svh
`ifndef KM_PARAMS_SVH
`define KM_PARAMS_SVH

// Datapath widths
`define KM_DATA_W   8
`define KM_DIMS     3
`define KM_CENTS    3
`define KM_IDX_W    2
// Two data widths for the square plus 2 bits of growth for the sum of three
`define KM_DIST_W   18
`define KM_SUM_W    16
`define KM_COUNT_W  9

// Point accepted to assignment out, in cycles
`define KM_LATENCY  6

// Reset coordinate of each centroid, same value in every dimension
`define KM_CENT0_INIT 0
`define KM_CENT1_INIT 1
`define KM_CENT2_INIT 2

`endif

// File: src/km_pkg.sv
`include "km_params.svh"

package km_pkg;

  // One coordinate
  typedef logic [`KM_DATA_W-1:0] data_t;

  // Dimension 0 sits in the low bits
  typedef data_t [`KM_DIMS-1:0] point_t;

  typedef logic [`KM_IDX_W-1:0] idx_t;

  typedef logic [`KM_DIST_W-1:0] dist_t;

  // All centroids side by side, centroid 0 in the low bits
  typedef point_t [`KM_CENTS-1:0] cent_set_t;

  typedef dist_t [`KM_CENTS-1:0] dist_set_t;

  // Per-dimension sum, wraps modulo its width
  typedef logic [`KM_SUM_W-1:0] sum_t;

  typedef sum_t [`KM_DIMS-1:0] sum_vec_t;

  typedef logic [`KM_COUNT_W-1:0] count_t;

endpackage

// File: src/km_top.sv
`timescale 1ns/1ps
`include "km_params.svh"

module km_top (
  input  logic             clk,
  input  logic             rst,
  // Host centroid write
  input  logic             i_cent_wr,
  input  km_pkg::idx_t     i_cent_idx,
  input  km_pkg::point_t   i_cent_point,
  // Point stream
  input  logic             i_valid,
  input  km_pkg::point_t   i_point,
  // Accumulator control and read-back
  input  logic             i_clear,
  input  logic             i_rd_en,
  input  km_pkg::idx_t     i_rd_idx,
  output logic             o_assign_valid,
  output km_pkg::idx_t     o_assign_idx,
  output km_pkg::dist_t    o_assign_dist,
  output km_pkg::point_t   o_assign_point,
  output logic             o_rd_valid,
  output km_pkg::sum_vec_t o_rd_sum,
  output km_pkg::count_t   o_rd_count
);

  km_pkg::cent_set_t cents;
  km_pkg::dist_set_t dists;

  km_centroid_regs u_cent_regs (
    .clk          (clk),
    .rst          (rst),
    .i_cent_wr    (i_cent_wr),
    .i_cent_idx   (i_cent_idx),
    .i_cent_point (i_cent_point),
    .o_cents      (cents)
  );

  // Distance stages, 3 cycles
  km_distance u_distance (
    .clk     (clk),
    .rst     (rst),
    .i_point (i_point),
    .i_cents (cents),
    .o_dists (dists)
  );

  // Compare tree, 3 more cycles
  km_argmin u_argmin (
    .clk     (clk),
    .rst     (rst),
    .i_dists (dists),
    .o_idx   (o_assign_idx),
    .o_dist  (o_assign_dist)
  );

  // Point and valid travel beside the arithmetic
  km_delay_line #(
    .T     (km_pkg::point_t),
    .DEPTH (`KM_LATENCY)
  ) u_point_dly (
    .clk    (clk),
    .rst    (rst),
    .i_data (i_point),
    .o_data (o_assign_point)
  );

  km_delay_line #(
    .T     (logic),
    .DEPTH (`KM_LATENCY)
  ) u_valid_dly (
    .clk    (clk),
    .rst    (rst),
    .i_data (i_valid),
    .o_data (o_assign_valid)
  );

  // Lands one edge after the assignment shows up
  km_accumulator u_accumulator (
    .clk         (clk),
    .rst         (rst),
    .i_clear     (i_clear),
    .i_acc_valid (o_assign_valid),
    .i_acc_idx   (o_assign_idx),
    .i_acc_point (o_assign_point),
    .i_rd_en     (i_rd_en),
    .i_rd_idx    (i_rd_idx),
    .o_rd_valid  (o_rd_valid),
    .o_rd_sum    (o_rd_sum),
    .o_rd_count  (o_rd_count)
  );

endmodule

// File: tb.f
+incdir+src
src/km_pkg.sv
src/km_centroid_regs.sv
src/km_distance.sv
src/km_argmin.sv
src/km_delay_line.sv
src/km_accumulator.sv
src/km_top.sv
tests/km_props.sv
tests/km_tb.sv

// File: tests/km_props.sv
`timescale 1ns/1ps

module km_props (
  input logic         clk,
  input logic         rst,
  input logic         i_rd_en,
  input logic         o_rd_valid,
  input logic         o_assign_valid,
  input km_pkg::idx_t o_assign_idx
);

  // Read response one cycle behind the request
  a_rd_follows: assert property (@(posedge clk) disable iff (rst)
    i_rd_en |=> o_rd_valid)
    else $error("o_rd_valid missing after i_rd_en");

  a_rd_no_spurious: assert property (@(posedge clk) disable iff (rst)
    !i_rd_en |=> !o_rd_valid)
    else $error("o_rd_valid without i_rd_en");

  a_idx_range: assert property (@(posedge clk) disable iff (rst)
    o_assign_valid |-> (o_assign_idx < 2'd3))
    else $error("o_assign_idx out of range");

  // Reset clears both valid strobes
  a_reset_quiet: assert property (@(posedge clk)
    rst |=> (!o_assign_valid && !o_rd_valid))
    else $error("valid strobe high during reset");

endmodule

bind km_top km_props u_props (
  .clk            (clk),
  .rst            (rst),
  .i_rd_en        (i_rd_en),
  .o_rd_valid     (o_rd_valid),
  .o_assign_valid (o_assign_valid),
  .o_assign_idx   (o_assign_idx)
);

// File: tests/km_tb.sv
`timescale 1ns/1ps
`include "km_params.svh"

module km_tb;

  localparam int OP_IDLE  = 0;
  localparam int OP_LOAD  = 1;
  localparam int OP_PUSH  = 2;
  localparam int OP_CLEAR = 3;
  localparam int OP_READ  = 4;
  localparam int MAX_ROWS = 64;
  localparam int DRAIN    = 8;

  logic clk;
  logic rst;
  logic i_cent_wr;
  km_pkg::idx_t i_cent_idx;
  km_pkg::point_t i_cent_point;
  logic i_valid;
  km_pkg::point_t i_point;
  logic i_clear;
  logic i_rd_en;
  km_pkg::idx_t i_rd_idx;
  logic o_assign_valid;
  km_pkg::idx_t o_assign_idx;
  km_pkg::dist_t o_assign_dist;
  km_pkg::point_t o_assign_point;
  logic o_rd_valid;
  km_pkg::sum_vec_t o_rd_sum;
  km_pkg::count_t o_rd_count;

  // Stimulus table, one row per cycle
  int row_op [MAX_ROWS];
  km_pkg::idx_t row_idx [MAX_ROWS];
  km_pkg::point_t row_pt [MAX_ROWS];
  int n_rows = 0;

  // Reference model state
  km_pkg::point_t m_cent [`KM_CENTS];
  km_pkg::sum_vec_t m_sum [`KM_CENTS];
  km_pkg::count_t m_count [`KM_CENTS];
  logic pend_acc;
  km_pkg::idx_t pend_idx;
  km_pkg::point_t pend_pt;

  // Expected results in flight
  km_pkg::idx_t q_idx [$];
  km_pkg::dist_t q_dist [$];
  km_pkg::point_t q_pt [$];
  int q_due [$];
  km_pkg::sum_vec_t r_sum [$];
  km_pkg::count_t r_count [$];
  int r_due [$];

  logic [31:0] lcg_state = 32'hab8c;
  int cyc = 0;
  int tick = 0;
  int limit = 1000;

  km_top UUT (
    .clk(clk), .rst(rst),
    .i_cent_wr(i_cent_wr), .i_cent_idx(i_cent_idx), .i_cent_point(i_cent_point),
    .i_valid(i_valid), .i_point(i_point),
    .i_clear(i_clear), .i_rd_en(i_rd_en), .i_rd_idx(i_rd_idx),
    .o_assign_valid(o_assign_valid), .o_assign_idx(o_assign_idx),
    .o_assign_dist(o_assign_dist), .o_assign_point(o_assign_point),
    .o_rd_valid(o_rd_valid), .o_rd_sum(o_rd_sum), .o_rd_count(o_rd_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    tick++;
    if (tick > limit) begin
      $display("Timeout: the run went past %0d cycles", limit);
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic km_pkg::point_t mk_point(input int a0, input int a1, input int a2);
    return {km_pkg::data_t'(a2), km_pkg::data_t'(a1), km_pkg::data_t'(a0)};
  endfunction

  function automatic km_pkg::point_t rand_point();
    lcg_state = lcg_next(lcg_state);
    return km_pkg::point_t'(lcg_state[31:8]);
  endfunction

  function automatic int sq_dist(input km_pkg::point_t a, input km_pkg::point_t b);
    int s;
    int diff;
    s = 0;
    for (int d = 0; d < `KM_DIMS; d++) begin
      diff = int'(a[d]) - int'(b[d]);
      s += diff * diff;
    end
    return s;
  endfunction

  task automatic add_row(input int op, input int idx, input km_pkg::point_t pt);
    row_op[n_rows] = op;
    row_idx[n_rows] = km_pkg::idx_t'(idx);
    row_pt[n_rows] = pt;
    n_rows++;
  endtask

  task automatic fail_plain(input string msg);
    $display("%s at %0t", msg, $time);
    $display("SOME TESTS FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic fail_value(input string name, input logic [71:0] got, input logic [71:0] exp);
    $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
    $display("SOME TESTS FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic check_idx(input string name, input km_pkg::idx_t got, input km_pkg::idx_t exp);
    if (got !== exp) fail_value(name, 72'(got), 72'(exp));
  endtask

  task automatic check_dist(input string name, input km_pkg::dist_t got, input km_pkg::dist_t exp);
    if (got !== exp) fail_value(name, 72'(got), 72'(exp));
  endtask

  task automatic check_point(input string name, input km_pkg::point_t got,
                             input km_pkg::point_t exp);
    if (got !== exp) fail_value(name, 72'(got), 72'(exp));
  endtask

  task automatic check_sum(input string name, input km_pkg::sum_vec_t got,
                           input km_pkg::sum_vec_t exp);
    if (got !== exp) fail_value(name, 72'(got), 72'(exp));
  endtask

  task automatic check_count(input string name, input km_pkg::count_t got,
                             input km_pkg::count_t exp);
    if (got !== exp) fail_value(name, 72'(got), 72'(exp));
  endtask

  // Outputs are sampled on the falling edge, half a cycle after they change
  task automatic check_outputs();
    pend_acc = 1'b0;
    if (o_assign_valid) begin
      if (q_idx.size() == 0) begin
        fail_plain("Assignment valid pulse with no point in flight");
      end else if (q_due[0] != cyc) begin
        fail_plain("Assignment arrived at the wrong cycle");
      end else begin
        check_idx("o_assign_idx", o_assign_idx, q_idx[0]);
        check_dist("o_assign_dist", o_assign_dist, q_dist[0]);
        check_point("o_assign_point", o_assign_point, q_pt[0]);
        pend_acc = 1'b1;
        pend_idx = q_idx.pop_front();
        pend_pt = q_pt.pop_front();
        void'(q_dist.pop_front());
        void'(q_due.pop_front());
      end
    end else if (q_due.size() != 0 && q_due[0] <= cyc) begin
      fail_plain("Expected assignment never appeared");
    end
    if (o_rd_valid) begin
      if (r_due.size() == 0) begin
        fail_plain("Read valid pulse without a read request");
      end else begin
        check_sum("o_rd_sum", o_rd_sum, r_sum.pop_front());
        check_count("o_rd_count", o_rd_count, r_count.pop_front());
        void'(r_due.pop_front());
      end
    end else if (r_due.size() != 0 && r_due[0] <= cyc) begin
      fail_plain("Read request got no valid response");
    end
  endtask

  task automatic step(input int op, input km_pkg::idx_t idx, input km_pkg::point_t pt);
    int best;
    int dd;
    km_pkg::idx_t best_idx;
    @(negedge clk);
    cyc++;
    check_outputs();
    i_cent_wr = (op == OP_LOAD);
    i_valid = (op == OP_PUSH);
    i_clear = (op == OP_CLEAR);
    i_rd_en = (op == OP_READ);
    i_cent_idx = idx;
    i_rd_idx = idx;
    i_cent_point = pt;
    i_point = pt;
    if (op == OP_LOAD && idx < `KM_CENTS) m_cent[idx] = pt;
    if (op == OP_PUSH) begin
      best = 1 << 30;
      best_idx = '0;
      // Highest index among equal minima
      for (int c = 0; c < `KM_CENTS; c++) begin
        dd = sq_dist(pt, m_cent[c]);
        if (dd <= best) begin
          best = dd;
          best_idx = km_pkg::idx_t'(c);
        end
      end
      q_idx.push_back(best_idx);
      q_dist.push_back(km_pkg::dist_t'(best));
      q_pt.push_back(pt);
      q_due.push_back(cyc + `KM_LATENCY);
    end
    // Read sees the value before an accumulation on the same edge
    if (op == OP_READ) begin
      r_sum.push_back(idx < `KM_CENTS ? m_sum[idx] : '0);
      r_count.push_back(idx < `KM_CENTS ? m_count[idx] : '0);
      r_due.push_back(cyc + 1);
    end
    if (op == OP_CLEAR) begin
      for (int c = 0; c < `KM_CENTS; c++) begin
        m_sum[c] = '0;
        m_count[c] = '0;
      end
    end else if (pend_acc) begin
      for (int d = 0; d < `KM_DIMS; d++) begin
        m_sum[pend_idx][d] = m_sum[pend_idx][d] + km_pkg::sum_t'(pend_pt[d]);
      end
      m_count[pend_idx] = m_count[pend_idx] + km_pkg::count_t'(1);
    end
  endtask

  task automatic build_table();
    // Default centroids
    add_row(OP_PUSH, 0, mk_point(0, 0, 0));
    add_row(OP_PUSH, 0, mk_point(1, 1, 1));
    add_row(OP_PUSH, 0, mk_point(2, 3, 4));
    // Back-to-back random points
    for (int i = 0; i < 6; i++) add_row(OP_PUSH, 0, rand_point());
    for (int i = 0; i < 8; i++) add_row(OP_IDLE, 0, '0);
    for (int i = 0; i < 4; i++) add_row(OP_READ, i, '0);
    add_row(OP_CLEAR, 0, '0);
    add_row(OP_READ, 0, '0);
    // New centroids, including ties
    add_row(OP_LOAD, 0, mk_point(10, 10, 10));
    add_row(OP_LOAD, 1, mk_point(20, 20, 20));
    add_row(OP_LOAD, 2, mk_point(200, 200, 200));
    add_row(OP_LOAD, 3, mk_point(1, 2, 3));
    add_row(OP_PUSH, 0, mk_point(15, 15, 15));
    add_row(OP_PUSH, 0, mk_point(5, 5, 5));
    add_row(OP_PUSH, 0, mk_point(210, 210, 210));
    add_row(OP_PUSH, 0, mk_point(110, 110, 110));
    for (int i = 0; i < 3; i++) add_row(OP_PUSH, 0, rand_point());
    for (int i = 0; i < 8; i++) add_row(OP_IDLE, 0, '0);
    for (int i = 0; i < 4; i++) add_row(OP_READ, i, '0);
  endtask

  initial begin
    rst = 1'b1;
    i_cent_wr = 1'b0;
    i_cent_idx = '0;
    i_cent_point = '0;
    i_valid = 1'b0;
    i_point = '0;
    i_clear = 1'b0;
    i_rd_en = 1'b0;
    i_rd_idx = '0;
    pend_acc = 1'b0;
    for (int c = 0; c < `KM_CENTS; c++) begin
      m_cent[c] = {`KM_DIMS{km_pkg::data_t'(c)}};
      m_sum[c] = '0;
      m_count[c] = '0;
    end
    build_table();
    limit = 5 + n_rows + DRAIN + 50;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int r = 0; r < n_rows; r++) begin
      step(row_op[r], row_idx[r], row_pt[r]);
    end
    for (int i = 0; i < DRAIN; i++) step(OP_IDLE, '0, '0);
    if (q_due.size() != 0 || r_due.size() != 0) begin
      fail_plain("Results still outstanding after the drain");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule
